/* design/node_rx.sv */
`timescale 1ns/10ps

module node_rx (
  input  logic              clk,
  input  logic              rst_b,
  input  logic              put_inbound,
  input  router_pkg::byte_t payload_inbound,
  input  logic              rx_release,
  output logic              free_inbound,
  output logic              pkt_ready,
  output router_pkg::pkt_t  pkt
);
  import router_pkg::*;

  typedef enum logic [1:0] {idle, loading, holding} rx_state_t;

  rx_state_t state, next_state;
  logic [1:0] byte_cnt;
  logic shift;

  always_comb begin
    next_state = state;
    shift = 1'b0;
    case (state)
      idle: begin
        // the put cycle already carries the first byte
        if (put_inbound) begin
          shift = 1'b1;
          next_state = loading;
        end
      end
      loading: begin
        shift = 1'b1;
        if (byte_cnt == 2'(PKT_BYTES - 1))
          next_state = holding;
      end
      holding: begin
        if (rx_release)
          next_state = idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state <= idle;
      byte_cnt <= '0;
      free_inbound <= 1'b1;
    end else begin
      state <= next_state;
      byte_cnt <= shift ? byte_cnt + 2'd1 : 2'd0;
      free_inbound <= (next_state == idle);
    end
  end

  // bytes arrive most significant first, so shift in from the bottom
  always_ff @(posedge clk) begin
    if (shift)
      pkt <= {pkt[23:0], payload_inbound};
  end

  assign pkt_ready = (state == holding);

  // a source may only start a packet while the port advertises free
  // put from the other router stays high for all four bytes and only its rise starts a packet
  assert property (@(posedge clk) disable iff (!rst_b) $rose(put_inbound) |-> free_inbound)
    else $error("node_rx: packet started while free_inbound is low");

endmodule

/* design/node_tx.sv */
`timescale 1ns/10ps

module node_tx (
  input  logic                                        clk,
  input  logic                                        rst_b,
  input  logic                                        load,
  input  router_pkg::port_id_t                        load_src,
  input  router_pkg::pkt_t [router_pkg::NUM_PORTS-1:0] pkts,
  input  logic                                        free_outbound,
  output logic                                        tx_empty,
  output logic                                        put_outbound,
  output router_pkg::byte_t                           payload_outbound
);
  import router_pkg::*;

  typedef enum logic {idle, sending} tx_state_t;

  tx_state_t state, next_state;
  byte_t [PKT_BYTES-1:0] held;
  logic [1:0] byte_cnt;
  logic done;

  always_comb begin
    next_state = state;
    done = 1'b0;
    case (state)
      idle: begin
        // the destination is only consulted before the first byte
        if (free_outbound && !tx_empty)
          next_state = sending;
      end
      sending: begin
        if (byte_cnt == 2'(PKT_BYTES - 1)) begin
          done = 1'b1;
          next_state = idle;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (load)
      held <= pkts[load_src];
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state <= idle;
      byte_cnt <= '0;
      tx_empty <= 1'b1;
      put_outbound <= 1'b0;
    end else begin
      state <= next_state;
      byte_cnt <= (state == sending && !done) ? byte_cnt + 2'd1 : 2'd0;
      if (done)
        tx_empty <= 1'b1;
      else if (load)
        tx_empty <= 1'b0;
      put_outbound <= (next_state == sending);
    end
  end

  assign payload_outbound = held[2'd3 - byte_cnt];

  assert property (@(posedge clk) disable iff (!rst_b) load |-> tx_empty)
    else $error("node_tx: load while a packet is still pending");

endmodule

/* design/port_queue.sv */
`timescale 1ns/10ps

module port_queue (
  input  logic                   clk,
  input  logic                   rst_b,
  input  logic                   enqueue,
  input  router_pkg::port_id_t   enqueue_src,
  input  logic                   tx_empty,
  output logic                   load,
  output router_pkg::port_id_t   load_src,
  output router_pkg::port_mask_t taken
);
  import router_pkg::*;

  typedef enum logic {idle, serving} q_state_t;

  q_state_t state, next_state;
  port_id_t ring [NUM_PORTS];
  port_id_t first, last;
  port_id_t head;
  logic [2:0] count;
  logic queue_empty;
  logic push, pop;

  assign queue_empty = (count == 3'd0);
  assign head = ring[first];

  always_comb begin
    next_state = state;
    load = 1'b0;
    load_src = head;
    push = 1'b0;
    pop = 1'b0;
    case (state)
      idle: begin
        // transmitter is known to be empty here, so load straight through
        if (enqueue) begin
          load = 1'b1;
          load_src = enqueue_src;
          next_state = serving;
        end
      end
      serving: begin
        case ({queue_empty, enqueue, tx_empty})
          3'b001: begin
            load = 1'b1;
            pop = 1'b1;
          end
          3'b010, 3'b110: push = 1'b1;
          3'b011: begin
            // oldest waiter goes out, the newcomer takes its place at the tail
            load = 1'b1;
            pop = 1'b1;
            push = 1'b1;
          end
          3'b101: next_state = idle;
          3'b111: begin
            load = 1'b1;
            load_src = enqueue_src;
          end
          default: ;
        endcase
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (push)
      ring[last] <= enqueue_src;
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state <= idle;
      first <= '0;
      last <= '0;
      count <= '0;
    end else begin
      state <= next_state;
      if (pop)
        first <= first + 2'd1;
      if (push)
        last <= last + 2'd1;
      if (push && !pop)
        count <= count + 3'd1;
      else if (pop && !push)
        count <= count - 3'd1;
    end
  end

  assign taken = load ? (port_mask_t'(1) << load_src) : '0;

  // each source holds at most one packet, so four waiters is the ceiling
  assert property (@(posedge clk) disable iff (!rst_b) count <= 3'd4)
    else $error("port_queue: count exceeds four");

endmodule

/* design/route_arbiter.sv */
`timescale 1ns/10ps

module route_arbiter #(
  parameter int ROUTER_ID = 0
) (
  input  logic                                              clk,
  input  logic                                              rst_b,
  input  router_pkg::port_mask_t                            pkt_ready,
  input  router_pkg::pkt_t [router_pkg::NUM_PORTS-1:0]       pkts,
  input  router_pkg::port_mask_t [router_pkg::NUM_PORTS-1:0] taken,
  output router_pkg::port_mask_t                            enqueue,
  output router_pkg::port_id_t [router_pkg::NUM_PORTS-1:0]   enqueue_src,
  output router_pkg::port_mask_t                            rx_release
);
  import router_pkg::*;

  typedef enum logic {waiting, sweeping} arb_state_t;

  arb_state_t state, next_state;
  port_mask_t queued;
  port_mask_t pending;
  port_mask_t visit_mask;
  logic [2:0] num_pending;
  port_id_t single_src;
  port_id_t prio;
  port_id_t sweep_ptr;
  logic [1:0] sweep_cnt;
  logic visit;
  port_id_t visit_src;
  port_id_t out_port;
  logic sweep_start;
  logic sweep_step;

  // sources with a packet that no output queue holds yet
  assign pending = pkt_ready & ~queued;
  assign num_pending = 3'($countones(pending));

  always_comb begin
    single_src = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (pending[i])
        single_src = port_id_t'(i);
    end
  end

  always_comb begin
    next_state = state;
    visit = 1'b0;
    visit_src = '0;
    sweep_start = 1'b0;
    sweep_step = 1'b0;
    case (state)
      waiting: begin
        if (num_pending == 3'd1) begin
          visit = 1'b1;
          visit_src = single_src;
        end else if (num_pending > 3'd1) begin
          // first visit of the sweep goes to the priority holder
          visit = pending[prio];
          visit_src = prio;
          sweep_start = 1'b1;
          next_state = sweeping;
        end
      end
      sweeping: begin
        visit = pending[sweep_ptr];
        visit_src = sweep_ptr;
        sweep_step = 1'b1;
        if (sweep_cnt == 2'd3)
          next_state = waiting;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state <= waiting;
      prio <= '0;
      sweep_ptr <= '0;
      sweep_cnt <= '0;
    end else begin
      state <= next_state;
      if (sweep_start) begin
        prio <= prio + 2'd1;
        sweep_ptr <= prio + 2'd1;
        sweep_cnt <= 2'd1;
      end else if (sweep_step) begin
        sweep_ptr <= sweep_ptr + 2'd1;
        sweep_cnt <= sweep_cnt + 2'd1;
      end
    end
  end

  always_comb begin
    enqueue = '0;
    enqueue_src = '0;
    out_port = route_port(ROUTER_ID, pkts[visit_src].dest_id);
    if (visit) begin
      enqueue[out_port] = 1'b1;
      enqueue_src[out_port] = visit_src;
    end
  end

  // every queue hands back the source it just loaded
  always_comb begin
    rx_release = '0;
    for (int p = 0; p < NUM_PORTS; p++)
      rx_release = rx_release | taken[p];
  end

  assign visit_mask = port_mask_t'(visit) << visit_src;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b)
      queued <= '0;
    else
      queued <= (queued | visit_mask) & ~rx_release;
  end

  // a queue may only hand back a source that this arbiter gave to an output
  assert property (@(posedge clk) disable iff (!rst_b)
                   (rx_release & ~(queued | visit_mask)) == '0)
    else $error("route_arbiter: release of a source that was never enqueued");

endmodule

/* design/router.sv */
`timescale 1ns/10ps

module router #(
  parameter int ROUTER_ID = 0
) (
  input  logic                                         clk,
  input  logic                                         rst_b,
  input  router_pkg::port_mask_t                       free_outbound,
  output router_pkg::port_mask_t                       put_outbound,
  output router_pkg::byte_t [router_pkg::NUM_PORTS-1:0] payload_outbound,
  output router_pkg::port_mask_t                       free_inbound,
  input  router_pkg::port_mask_t                       put_inbound,
  input  router_pkg::byte_t [router_pkg::NUM_PORTS-1:0] payload_inbound
);
  import router_pkg::*;

  pkt_t [NUM_PORTS-1:0] pkts;
  port_mask_t pkt_ready, enqueue, rx_release, load, tx_empty;
  port_id_t [NUM_PORTS-1:0] enqueue_src, load_src;
  port_mask_t [NUM_PORTS-1:0] taken;

  route_arbiter #(.ROUTER_ID(ROUTER_ID)) u_arbiter (
    .clk, .rst_b, .pkt_ready, .pkts, .taken, .enqueue, .enqueue_src, .rx_release
  );

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    node_rx u_rx (
      .clk, .rst_b, .put_inbound(put_inbound[p]), .payload_inbound(payload_inbound[p]),
      .rx_release(rx_release[p]), .free_inbound(free_inbound[p]),
      .pkt_ready(pkt_ready[p]), .pkt(pkts[p])
    );

    port_queue u_queue (
      .clk, .rst_b, .enqueue(enqueue[p]), .enqueue_src(enqueue_src[p]),
      .tx_empty(tx_empty[p]), .load(load[p]), .load_src(load_src[p]), .taken(taken[p])
    );

    node_tx u_tx (
      .clk, .rst_b, .load(load[p]), .load_src(load_src[p]), .pkts,
      .free_outbound(free_outbound[p]), .tx_empty(tx_empty[p]),
      .put_outbound(put_outbound[p]), .payload_outbound(payload_outbound[p])
    );
  end

endmodule

/* design/router_pkg.sv */
package router_pkg;

  localparam int NUM_PORTS = 4;
  localparam int PKT_BYTES = 4;
  // nodes 0 to 2 hang off router 0, nodes 3 to 5 off router 1
  localparam int NODES_PER_ROUTER = 3;

  typedef logic [1:0] port_id_t;
  typedef logic [3:0] node_id_t;
  typedef logic [7:0] byte_t;
  typedef logic [NUM_PORTS-1:0] port_mask_t;

  typedef struct packed {
    node_id_t    src_id;
    node_id_t    dest_id;
    logic [23:0] data;
  } pkt_t;

  // maps a destination node to the output port of the given router
  function automatic port_id_t route_port(input int router_id, input node_id_t dest);
    port_id_t port;
    if (router_id == 0) begin
      // port 1 is the link to the other router, local nodes sit on 0, 2 and 3
      if (dest >= NODES_PER_ROUTER)
        port = 2'd1;
      else if (dest == '0)
        port = 2'd0;
      else
        port = port_id_t'(dest + 4'd1);
    end else begin
      if (dest < NODES_PER_ROUTER)
        port = 2'd3;
      else
        port = port_id_t'(dest - 4'd3);
    end
    return port;
  endfunction

endpackage

/* sim.f */
design/router_pkg.sv
design/node_rx.sv
design/route_arbiter.sv
design/port_queue.sv
design/node_tx.sv
design/router.sv
tb/router_tb.sv

/* tb/router_stimulus.txt */
// columns: test, send cycle, sender node, packet word, hold mask (bit n holds node n)
// all values hex, the all-pairs test is generated in the testbench, ff ends the list
// four senders in one cycle, four different destinations
3 190 0 04a1b2c3 00
3 190 2 21d4e5f6 00
3 190 3 35112233 00
3 190 5 50445566 00
// three senders to node 2, node 1 sends twice
4 1f4 1 12000001 00
4 1f4 3 32000002 00
4 1f4 4 42000003 00
4 1f4 1 12000004 00
// node 4 holds free_outbound low while five packets head for it
5 258 0 04abcdef 10
5 258 1 14bcdef0 00
5 258 2 24cdef01 00
5 258 3 34def012 00
5 258 5 54ef0123 00
ff

/* tb/router_tb.sv */
`timescale 1ns/10ps

module router_tb;
  import router_pkg::*;

  localparam int NUM_NODES = 6;
  localparam int MAX_PKTS = 64;
  localparam int FILE_WORDS = 160;

  logic clk;
  logic rst_b;
  port_mask_t put_in0, put_in1, put_out0, put_out1;
  port_mask_t free_in0, free_in1, free_out0, free_out1;
  byte_t [NUM_PORTS-1:0] pay_in0, pay_in1, pay_out0, pay_out1;

  // node side of every link, node n sits at index n
  logic [NUM_NODES-1:0] node_put, node_free, node_put_out, node_free_in;
  logic [NUM_NODES-1:0] prev_put, prev_free;
  byte_t [NUM_NODES-1:0] node_pay, node_pay_out;

  logic [31:0] stim [FILE_WORDS];
  int rec_test [MAX_PKTS];
  int rec_cycle [MAX_PKTS];
  int rec_src [MAX_PKTS];
  logic [31:0] rec_word [MAX_PKTS];
  logic [5:0] rec_hold [MAX_PKTS];
  logic rec_sent [MAX_PKTS];
  logic rec_recv [MAX_PKTS];
  int test_total [6];
  int test_recv [6];
  int tx_cnt [NUM_NODES];
  int rx_cnt [NUM_NODES];
  int hold_until [NUM_NODES];
  logic [31:0] tx_word [NUM_NODES];
  logic [31:0] rx_word [NUM_NODES];
  int n_recs, recv_count, errors, limit, cycle;

  router #(.ROUTER_ID(0)) dut0 (
    .clk, .rst_b, .free_outbound(free_out0), .put_outbound(put_out0),
    .payload_outbound(pay_out0), .free_inbound(free_in0),
    .put_inbound(put_in0), .payload_inbound(pay_in0)
  );

  router #(.ROUTER_ID(1)) dut1 (
    .clk, .rst_b, .free_outbound(free_out1), .put_outbound(put_out1),
    .payload_outbound(pay_out1), .free_inbound(free_in1),
    .put_inbound(put_in1), .payload_inbound(pay_in1)
  );

  // port 1 of dut0 and port 3 of dut1 form the link between the routers
  assign put_in0 = {node_put[2], node_put[1], put_out1[3], node_put[0]};
  assign pay_in0 = {node_pay[2], node_pay[1], pay_out1[3], node_pay[0]};
  assign free_out0 = {node_free[2], node_free[1], free_in1[3], node_free[0]};
  assign put_in1 = {put_out0[1], node_put[5:3]};
  assign pay_in1 = {pay_out0[1], node_pay[5:3]};
  assign free_out1 = {free_in0[1], node_free[5:3]};
  assign node_put_out = {put_out1[2:0], put_out0[3:2], put_out0[0]};
  assign node_pay_out = {pay_out1[2:0], pay_out0[3:2], pay_out0[0]};
  assign node_free_in = {free_in1[2:0], free_in0[3:2], free_in0[0]};

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int first_unsent(input int node);
    int idx;
    idx = -1;
    for (int i = n_recs - 1; i >= 0; i--) begin
      if (!rec_sent[i] && rec_src[i] == node)
        idx = i;
    end
    return idx;
  endfunction

  task automatic add_packet(input int t, input int cyc, input int src, input logic [31:0] word,
                            input logic [5:0] hold);
    rec_test[n_recs] = t;
    rec_cycle[n_recs] = cyc;
    rec_src[n_recs] = src;
    rec_word[n_recs] = word;
    rec_hold[n_recs] = hold;
    rec_sent[n_recs] = 1'b0;
    rec_recv[n_recs] = 1'b0;
    test_total[t]++;
    n_recs++;
  endtask

  task automatic load_packets();
    logic [31:0] seed;
    int k;
    seed = 32'h7100_a42a;
    // every node sends once to every other node, with random data
    for (int s = 0; s < NUM_NODES; s++) begin
      for (int d = 0; d < NUM_NODES; d++) begin
        if (d != s) begin
          seed = xorshift(seed);
          add_packet(2, 10, s, {4'(s), 4'(d), seed[23:0]}, 6'b0);
        end
      end
    end
    $readmemh("tb/router_stimulus.txt", stim);
    k = 0;
    while (k < FILE_WORDS && !$isunknown(stim[k]) && stim[k] != 32'hff) begin
      add_packet(stim[k], stim[k+1], stim[k+2], stim[k+3], stim[k+4]);
      k = k + 5;
    end
  endtask

  // the oldest outstanding packet of this sender to this node is the expected one
  task automatic check_packet(input int node, input logic [31:0] word);
    int idx;
    int t;
    idx = -1;
    for (int i = n_recs - 1; i >= 0; i--) begin
      if (rec_sent[i] && !rec_recv[i] && rec_src[i] == int'(word[31:28]) &&
          int'(rec_word[i][27:24]) == node)
        idx = i;
    end
    assert (idx >= 0) else begin
      $display("node %0d received packet %h that no sender addressed to it", node, word);
      errors++;
    end
    if (idx >= 0) begin
      assert (word == rec_word[idx]) else begin
        $display("mismatch at %0t: payload_outbound of node %0d got %h expected %h",
                 $time, node, word, rec_word[idx]);
        errors++;
      end
      t = rec_test[idx];
      rec_recv[idx] = 1'b1;
      recv_count++;
      test_recv[t]++;
      if (test_recv[t] == test_total[t])
        $display("test %0d finished at %0t: %0d packets, %0d errors so far",
                 t, $time, test_total[t], errors);
    end
  endtask

  always @(posedge clk) begin : drive_nodes
    int pick;
    if (rst_b) begin
      for (int i = 0; i < n_recs; i++) begin
        if (rec_cycle[i] == cycle) begin
          for (int m = 0; m < NUM_NODES; m++)
            if (rec_hold[i][m])
              hold_until[m] = cycle + 40;
        end
      end
    end
    for (int n = 0; n < NUM_NODES; n++) begin
      node_free[n] <= (cycle >= hold_until[n]);
      node_put[n] <= 1'b0;
      if (tx_cnt[n] == 0) begin
        pick = first_unsent(n);
        if (rst_b && pick >= 0 && rec_cycle[pick] <= cycle && node_free_in[n]) begin
          rec_sent[pick] = 1'b1;
          tx_word[n] = rec_word[pick];
          tx_cnt[n] = 1;
          node_put[n] <= 1'b1;
          node_pay[n] <= rec_word[pick][31:24];
        end
      end else begin
        node_pay[n] <= tx_word[n][8*(3-tx_cnt[n]) +: 8];
        tx_cnt[n] = (tx_cnt[n] + 1) % 4;
      end
    end
    cycle <= rst_b ? cycle + 1 : 0;
  end

  always @(negedge clk) begin : collect_nodes
    for (int n = 0; n < NUM_NODES; n++) begin
      if (rst_b) begin
        // the transmitter decided on the previous cycle's free level
        assert (!(node_put_out[n] && !prev_put[n] && !prev_free[n])) else begin
          $display("node %0d: put_outbound rose while free_outbound was held low", n);
          errors++;
        end
        assert (node_put_out[n] || rx_cnt[n] == 0) else begin
          $display("node %0d: put_outbound dropped after %0d bytes", n, rx_cnt[n]);
          errors++;
          rx_cnt[n] = 0;
        end
        if (node_put_out[n]) begin
          rx_word[n] = {rx_word[n][23:0], node_pay_out[n]};
          rx_cnt[n]++;
          if (rx_cnt[n] == 4) begin
            check_packet(n, rx_word[n]);
            rx_cnt[n] = 0;
          end
        end
      end
    end
    prev_put = node_put_out;
    prev_free = node_free;
  end

  initial begin
    clk = 1'b0;
    rst_b = 1'b0;
    node_put = '0;
    node_free = '1;
    node_pay = '0;
    prev_put = '0;
    prev_free = '1;
    cycle = 0;
    errors = 0;
    recv_count = 0;
    n_recs = 0;
    limit = 0;
    for (int n = 0; n < NUM_NODES; n++) begin
      tx_cnt[n] = 0;
      rx_cnt[n] = 0;
      hold_until[n] = 0;
    end
    for (int t = 0; t < 6; t++) begin
      test_total[t] = 0;
      test_recv[t] = 0;
    end
    load_packets();
    for (int i = 0; i < n_recs; i++)
      if (rec_cycle[i] > limit)
        limit = rec_cycle[i];
    limit = limit + 60 * n_recs;
    repeat (4) @(posedge clk);
    rst_b <= 1'b1;
    @(negedge clk);
    assert (free_in0 == '1 && free_in1 == '1) else begin
      $display("mismatch at %0t: free_inbound got %b %b expected 1111 1111",
               $time, free_in0, free_in1);
      errors++;
    end
    assert (put_out0 == '0 && put_out1 == '0) else begin
      $display("mismatch at %0t: put_outbound got %b %b expected 0000 0000",
               $time, put_out0, put_out1);
      errors++;
    end
    $display("test 1 finished at %0t: reset values, %0d errors so far", $time, errors);
    while (recv_count < n_recs && cycle < limit)
      @(posedge clk);
    if (recv_count < n_recs) begin
      $display("timeout after %0d cycles with %0d of %0d packets delivered",
               cycle, recv_count, n_recs);
      errors++;
    end else begin
      // give a duplicate packet time to show up
      repeat (20) @(posedge clk);
    end
    $display("5 tests, %0d of %0d packets delivered, %0d errors", recv_count, n_recs, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule
